// File: common/cpu_pkg.sv
package cpu_pkg;

  localparam int addr_w      = 10;  // 1024 byte address space
  localparam int data_w      = 8;
  localparam int reg_w       = 16;
  localparam int reg_count   = 32;
  localparam int reg_sel_w   = $clog2(reg_count);  // low bits of the register byte
  localparam int instr_bytes = 4;

  // opcode byte values
  localparam logic [data_w-1:0] opc_jmp     = 8'd1;
  localparam logic [data_w-1:0] opc_ram2reg = 8'd2;
  localparam logic [data_w-1:0] opc_reg2ram = 8'd3;
  localparam logic [data_w-1:0] opc_num2reg = 8'd4;

  // sticky status bits on led
  localparam int led_jmp     = 1;
  localparam int led_ram2reg = 2;
  localparam int led_reg2ram = 3;
  localparam int led_num2reg = 4;

  // first fetched byte lands in the top byte
  typedef struct packed {
    logic [data_w-1:0] opcode;
    logic [data_w-1:0] mode;    // not decoded
    logic [reg_w-1:0]  target;  // low addr_w bits used
  } jmp_word_t;

  typedef struct packed {
    logic [data_w-1:0] opcode;
    logic [data_w-1:0] rsel;     // register byte
    logic [reg_w-1:0]  operand;  // immediate or byte address
  } data_word_t;

  typedef union packed {
    jmp_word_t  jmp;
    data_word_t data;
  } instr_word_u;

endpackage

// File: hdl/program_memory.sv
`timescale 1ns/1ps

module program_memory
  import cpu_pkg::*;
#(
  parameter int mem_depth = 1024
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              load_en,
  input  logic [addr_w-1:0] load_addr,
  input  logic [data_w-1:0] load_data,
  input  logic [addr_w-1:0] fetch_addr,
  input  logic [addr_w-1:0] ex_addr,
  input  logic              ex_write,
  input  logic [data_w-1:0] ex_wdata,
  output logic [data_w-1:0] fetch_data,
  output logic [data_w-1:0] ex_rdata
);

  logic [data_w-1:0] mem [mem_depth];

  logic              wr_en;
  logic [addr_w-1:0] port_addr;
  logic [data_w-1:0] wr_data;

  // load port owns the second port while in reset
  assign wr_en     = rst ? load_en : ex_write;
  assign port_addr = rst ? load_addr : ex_addr;
  assign wr_data   = rst ? load_data : ex_wdata;

  // read/write port, old data on a same-address write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[port_addr] <= wr_data;
    end
    ex_rdata <= mem[port_addr];
  end

  // fetch port, read only
  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];
  end

endmodule

// File: fetch/instr_fetcher.sv
`timescale 1ns/1ps

module instr_fetcher
  import cpu_pkg::*;
#(
  parameter int program_base = 92,
  parameter int mem_depth    = 1024
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [data_w-1:0] fetch_data,
  input  logic              instr_done,
  input  logic              jump_set,
  input  logic [addr_w-1:0] jump_target,
  output logic [addr_w-1:0] fetch_addr,
  output logic              instr_valid,
  output instr_word_u       instr,
  output logic [addr_w-1:0] instr_pc
);

  logic [addr_w-1:0] base_pc;    // address of the word being fetched or held
  logic [addr_w-1:0] pc_next;
  logic [2:0]        req_idx;    // next byte to request, 4 = all requested
  logic              issue;
  logic              rd_valid;   // fetch_data holds a requested byte
  logic              rd_last;    // ... and it is the fourth one
  logic              buf_full;
  logic              in_flight;  // executor holds an unfinished instruction
  logic [instr_bytes-1:0][data_w-1:0] buf_bytes;

  assign issue = !req_idx[2];

  // redirect reads the target in the jump cycle itself
  assign fetch_addr = jump_set ? jump_target : base_pc + addr_w'(req_idx);

  assign pc_next = (base_pc >= addr_w'(mem_depth - instr_bytes)) ? '0
                 : base_pc + addr_w'(instr_bytes);

  // a jump in progress kills the buffered word
  assign instr_valid = buf_full && (!in_flight || instr_done) && !jump_set;
  assign instr       = buf_bytes;
  assign instr_pc    = base_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      base_pc   <= addr_w'(program_base);
      req_idx   <= '0;
      rd_valid  <= 1'b0;
      rd_last   <= 1'b0;
      buf_full  <= 1'b0;
      in_flight <= 1'b0;
    end else if (jump_set) begin
      base_pc   <= jump_target;
      req_idx   <= 3'd1;  // byte 0 already requested
      rd_valid  <= 1'b1;
      rd_last   <= 1'b0;
      buf_full  <= 1'b0;
      in_flight <= 1'b0;  // jump finishes now
    end else begin
      rd_valid <= issue;
      rd_last  <= issue && (req_idx == 3'd3);
      if (issue) begin
        req_idx <= req_idx + 3'd1;
      end
      if (rd_valid && rd_last) begin
        buf_full <= 1'b1;
      end
      if (instr_valid) begin
        buf_full  <= 1'b0;
        base_pc   <= pc_next;
        req_idx   <= '0;  // start prefetching the next word
        in_flight <= 1'b1;
      end else if (instr_done) begin
        in_flight <= 1'b0;
      end
    end
  end

  // bytes shift in from the bottom, opcode ends on top
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      buf_bytes <= {buf_bytes[instr_bytes-2:0], fetch_data};
    end
  end

endmodule

// File: execute/instr_executor.sv
`timescale 1ns/1ps

module instr_executor
  import cpu_pkg::*;
#(
  parameter int mem_depth = 1024
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  instr_word_u       instr,
  input  logic [addr_w-1:0] instr_pc,
  input  logic [data_w-1:0] ex_rdata,
  output logic              instr_done,
  output logic              jump_set,
  output logic [addr_w-1:0] jump_target,
  output logic [addr_w-1:0] ex_addr,
  output logic              ex_write,
  output logic [data_w-1:0] ex_wdata,
  output logic [7:0]        led
);

  logic [reg_w-1:0] regs [reg_count];

  logic                 busy;    // ram2reg read in progress
  logic                 ld_fin;  // ram2reg byte on ex_rdata
  logic [reg_sel_w-1:0] ld_sel;

  logic [data_w-1:0]    opc;
  logic [reg_sel_w-1:0] sel;
  logic [addr_w-1:0]    opnd_addr;
  logic [addr_w-1:0]    tgt_addr;
  logic [addr_w-1:0]    seq_pc;
  logic [reg_w-1:0]     ld_val;
  logic [reg_w-1:0]     src_val;

  assign opc       = instr.data.opcode;
  assign sel       = instr.data.rsel[reg_sel_w-1:0];
  assign opnd_addr = instr.data.operand[addr_w-1:0];
  assign tgt_addr  = instr.jmp.target[addr_w-1:0];

  // where the fetcher goes anyway without a redirect
  assign seq_pc = (instr_pc >= addr_w'(mem_depth - instr_bytes)) ? '0
                : instr_pc + addr_w'(instr_bytes);

  assign ld_val = {{(reg_w - data_w){1'b0}}, ex_rdata};

  // bypass a load that completes while a store reads the same register
  assign src_val = (ld_fin && ld_sel == sel) ? ld_val : regs[sel];

  always_ff @(posedge clk) begin
    if (rst) begin
      instr_done <= 1'b0;
      jump_set   <= 1'b0;
      ex_write   <= 1'b0;
      busy       <= 1'b0;
      ld_fin     <= 1'b0;
      led        <= '0;
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      instr_done <= busy;  // ram2reg done one cycle after its read
      ld_fin     <= busy;
      busy       <= 1'b0;
      jump_set   <= 1'b0;
      ex_write   <= 1'b0;

      // load result first so a num2reg in this cycle wins
      if (ld_fin) begin
        regs[ld_sel] <= ld_val;
      end

      if (instr_valid) begin
        instr_done <= 1'b1;
        case (opc)
          opc_jmp: begin
            jump_target <= tgt_addr;
            // jump to the next word needs no redirect
            jump_set     <= (tgt_addr != seq_pc);
            led[led_jmp] <= 1'b1;
          end
          opc_ram2reg: begin
            instr_done       <= 1'b0;
            busy             <= 1'b1;
            ex_addr          <= opnd_addr;
            ld_sel           <= sel;
            led[led_ram2reg] <= 1'b1;
          end
          opc_reg2ram: begin
            ex_addr          <= opnd_addr;
            ex_wdata         <= src_val[data_w-1:0];  // low byte only
            ex_write         <= 1'b1;
            led[led_reg2ram] <= 1'b1;
          end
          opc_num2reg: begin
            regs[sel]        <= instr.data.operand;
            led[led_num2reg] <= 1'b1;
          end
          default: begin
            // unknown opcode, finishes as a no-op
          end
        endcase
      end
    end
  end

endmodule

// File: hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
#(
  parameter int program_base = 92,
  parameter int mem_depth    = 1024
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              load_en,
  input  logic [addr_w-1:0] load_addr,
  input  logic [data_w-1:0] load_data,
  output logic [7:0]        led,
  output logic              mem_write,
  output logic [addr_w-1:0] mem_write_addr,
  output logic [data_w-1:0] mem_write_data
);

  logic [addr_w-1:0] fetch_addr;
  logic [data_w-1:0] fetch_data;
  logic [data_w-1:0] ex_rdata;

  logic              instr_valid;
  instr_word_u       instr;
  logic [addr_w-1:0] instr_pc;
  logic              instr_done;
  logic              jump_set;
  logic [addr_w-1:0] jump_target;

  // executor memory port doubles as the visible write port
  program_memory #(
    .mem_depth(mem_depth)
  ) program_memory_inst (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .fetch_addr(fetch_addr),
    .ex_addr   (mem_write_addr),
    .ex_write  (mem_write),
    .ex_wdata  (mem_write_data),
    .fetch_data(fetch_data),
    .ex_rdata  (ex_rdata)
  );

  instr_fetcher #(
    .program_base(program_base),
    .mem_depth   (mem_depth)
  ) instr_fetcher_inst (
    .clk        (clk),
    .rst        (rst),
    .fetch_data (fetch_data),
    .instr_done (instr_done),
    .jump_set   (jump_set),
    .jump_target(jump_target),
    .fetch_addr (fetch_addr),
    .instr_valid(instr_valid),
    .instr      (instr),
    .instr_pc   (instr_pc)
  );

  instr_executor #(
    .mem_depth(mem_depth)
  ) instr_executor_inst (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .instr      (instr),
    .instr_pc   (instr_pc),
    .ex_rdata   (ex_rdata),
    .instr_done (instr_done),
    .jump_set   (jump_set),
    .jump_target(jump_target),
    .ex_addr    (mem_write_addr),
    .ex_write   (mem_write),
    .ex_wdata   (mem_write_data),
    .led        (led)
  );

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int half_period  = 2,
  parameter int reset_cycles = 16
) (
  input  logic hold,  // keeps reset asserted while high
  output logic clk,
  output logic rst
);

  int count = 0;  // cycles since hold dropped

  always @(posedge clk) begin
    if (hold) begin
      count <= 0;
    end else if (count < reset_cycles) begin
      count <= count + 1;
    end
  end

  // reset follows the falling edge like the other inputs
  initial begin
    clk = 1'b1;
    rst = 1'b1;
    forever begin
      #(half_period);
      clk = ~clk;
      if (!clk) begin
        rst <= (count < reset_cycles);
      end
    end
  end

endmodule

// File: sim/cpu_assert.sv
`timescale 1ns/1ps

module cpu_assert (
  input logic clk,
  input logic rst,
  input logic instr_valid,
  input logic instr_done,
  input logic jump_set,
  input logic ex_write
);

  logic pending;        // executor holds an unfinished instruction
  int   fail_count = 0;

  always @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (instr_valid) begin
      pending <= 1'b1;
    end else if (instr_done) begin
      pending <= 1'b0;
    end
  end

  no_overlap: assert property (@(posedge clk) disable iff (rst)
    instr_valid |-> (!pending || instr_done))
    else begin
      $error("instruction handed over while the executor is busy");
      fail_count++;
    end

  single_write: assert property (@(posedge clk) disable iff (rst)
    ex_write |=> !ex_write)
    else begin
      $error("ex_write held for more than one cycle");
      fail_count++;
    end

  jump_done: assert property (@(posedge clk) disable iff (rst)
    jump_set |-> instr_done)
    else begin
      $error("jump_set without instr_done");
      fail_count++;
    end

endmodule

// File: sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
  import cpu_pkg::*;
();

  localparam int program_base  = 92;
  localparam int mem_bytes     = 1 << addr_w;
  localparam int reset_cycles  = 16;
  localparam int n_tests       = 5;
  localparam int rand_count    = 24;
  localparam int load_budget   = 128;  // upper bound of bytes loaded per test
  localparam int settle_cycles = 16;   // quiet time to catch extra writes
  localparam int instr_cycles  = 5;    // fetch time of one word
  localparam int instr_total   = 3 + 4 + 4 + 5 + (rand_count + 1);
  localparam int timeout_limit = n_tests * (reset_cycles + load_budget + settle_cycles)
                               + 8 * instr_total + 500;

  logic              clk;
  logic              rst;
  logic              hold;
  logic              load_en;
  logic [addr_w-1:0] load_addr;
  logic [data_w-1:0] load_data;
  logic [7:0]        led;
  logic              mem_write;
  logic [addr_w-1:0] mem_write_addr;
  logic [data_w-1:0] mem_write_data;

  logic [data_w-1:0] image [mem_bytes];  // tb copy of memory and the model's memory
  logic [addr_w-1:0] load_list [$];
  logic [addr_w-1:0] exp_addr [$];
  logic [data_w-1:0] exp_data [$];
  logic [addr_w-1:0] got_addr [$];
  logic [data_w-1:0] got_data [$];
  logic [7:0]        exp_led;

  int errors = 0;
  int cycles = 0;
  int seed;
  int assert_fails;
  int model_steps;  // instructions the model ran up to its halt

  clk_gen #(
    .half_period (2),
    .reset_cycles(reset_cycles)
  ) clk_gen_inst (
    .hold(hold),
    .clk (clk),
    .rst (rst)
  );

  cpu_top #(
    .program_base(program_base),
    .mem_depth   (mem_bytes)
  ) cpu_top_inst (
    .clk           (clk),
    .rst           (rst),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .led           (led),
    .mem_write     (mem_write),
    .mem_write_addr(mem_write_addr),
    .mem_write_data(mem_write_data)
  );

  bind instr_executor cpu_assert cpu_assert_inst (
    .clk        (clk),
    .rst        (rst),
    .instr_valid(instr_valid),
    .instr_done (instr_done),
    .jump_set   (jump_set),
    .ex_write   (ex_write)
  );

  // write monitor cleared while in reset
  always @(negedge clk) begin
    if (rst) begin
      got_addr.delete();
      got_data.delete();
    end else if (mem_write) begin
      got_addr.push_back(mem_write_addr);
      got_data.push_back(mem_write_data);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("timeout after %0d cycles, expected writes never arrived", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] data_word(input logic [7:0] opc, input logic [7:0] rsel,
                                            input logic [15:0] operand);
    return {opc, rsel, operand};
  endfunction

  function automatic logic [31:0] jmp_word(input logic [15:0] target);
    return {opc_jmp, 8'h00, target};  // mode byte unused
  endfunction

  task automatic put_byte(input int addr, input logic [7:0] value);
    image[addr_w'(addr)] = value;
    load_list.push_back(addr_w'(addr));
  endtask

  task automatic put_word(input int addr, input logic [31:0] word);
    for (int i = 0; i < instr_bytes; i++) begin
      put_byte(addr + i, word[31 - 8*i -: 8]);  // opcode byte first
    end
  endtask

  task automatic new_program();
    load_list.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  // executes the image from the reset pc until a jump to itself
  task automatic run_model();
    logic [reg_w-1:0]  regs [reg_count];
    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] opnd;
    logic [7:0]        opc;
    logic [7:0]        rbyte;
    logic [4:0]        sel;
    logic [15:0]       operand;
    logic              halted;
    int                steps;
    for (int i = 0; i < reg_count; i++) begin
      regs[i] = '0;
    end
    pc      = addr_w'(program_base);
    exp_led = '0;
    halted  = 1'b0;
    steps   = 0;
    while (!halted && steps < 1000) begin
      opc     = image[pc];
      rbyte   = image[addr_w'(pc + 1)];
      sel     = rbyte[4:0];
      operand = {image[addr_w'(pc + 2)], image[addr_w'(pc + 3)]};
      opnd    = operand[addr_w-1:0];
      steps++;
      if (opc == opc_jmp) begin
        exp_led[led_jmp] = 1'b1;
        if (opnd == pc) begin
          halted = 1'b1;
        end
        pc = opnd;
      end else begin
        case (opc)
          opc_ram2reg: begin
            regs[sel] = reg_w'(image[opnd]);
            exp_led[led_ram2reg] = 1'b1;
          end
          opc_reg2ram: begin
            exp_addr.push_back(opnd);
            exp_data.push_back(regs[sel][7:0]);
            image[opnd] = regs[sel][7:0];
            exp_led[led_reg2ram] = 1'b1;
          end
          opc_num2reg: begin
            regs[sel] = operand;
            exp_led[led_num2reg] = 1'b1;
          end
          default: begin
          end
        endcase
        pc = pc + addr_w'(instr_bytes);  // wraps at the end of memory
      end
    end
    model_steps = steps;
  endtask

  task automatic check_results(input string name);
    assert (got_addr.size() == exp_addr.size()) else begin
      errors++;
      $display("Mismatch at %0t: %s mem_write count got %0d expected %0d",
               $time, name, got_addr.size(), exp_addr.size());
    end
    for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
      assert (got_addr[i] == exp_addr[i]) else begin
        errors++;
        $display("Mismatch at %0t: %s mem_write_addr[%0d] got %h expected %h",
                 $time, name, i, got_addr[i], exp_addr[i]);
      end
      assert (got_data[i] == exp_data[i]) else begin
        errors++;
        $display("Mismatch at %0t: %s mem_write_data[%0d] got %h expected %h",
                 $time, name, i, got_data[i], exp_data[i]);
      end
    end
    assert (led == exp_led) else begin
      errors++;
      $display("Mismatch at %0t: %s led got %h expected %h", $time, name, led, exp_led);
    end
  endtask

  task automatic run_program(input string name);
    int run_cycles;
    @(negedge clk);
    hold = 1'b1;
    while (!rst) @(negedge clk);
    foreach (load_list[i]) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = load_list[i];
      load_data = image[load_list[i]];
    end
    @(negedge clk);
    load_en = 1'b0;
    run_model();  // model stores land in the image after loading
    hold = 1'b0;
    while (rst) @(negedge clk);
    run_cycles = 0;
    // all writes seen and the halting jump reached
    while (got_addr.size() < exp_addr.size() || run_cycles < instr_cycles * model_steps) begin
      @(negedge clk);
      run_cycles++;
    end
    repeat (settle_cycles) @(negedge clk);
    check_results(name);
  endtask

  task automatic num2reg_then_store();
    new_program();
    put_word(program_base,     data_word(opc_num2reg, 8'd2, 16'hbeef));
    put_word(program_base + 4, data_word(opc_reg2ram, 8'd2, 16'h0300));
    put_word(program_base + 8, jmp_word(16'(program_base + 8)));
    run_program("num2reg_store");
  endtask

  task automatic ram2reg_copy();
    new_program();
    put_byte('h320, 8'hc3);
    put_word(program_base,      data_word(opc_num2reg, 8'd5, 16'h1234));
    put_word(program_base + 4,  data_word(opc_ram2reg, 8'd5, 16'h0320));
    put_word(program_base + 8,  data_word(opc_reg2ram, 8'd5, 16'h0330));  // right behind the load
    put_word(program_base + 12, jmp_word(16'(program_base + 12)));
    run_program("ram2reg_copy");
  endtask

  task automatic jump_skips_next();
    new_program();
    put_word(program_base,     jmp_word(16'd200));
    put_word(program_base + 4, data_word(opc_reg2ram, 8'd1, 16'h0310));  // must be skipped
    put_word(program_base + 8, jmp_word(16'(program_base + 8)));
    put_word(200, data_word(opc_num2reg, 8'd1, 16'h00a7));
    put_word(204, data_word(opc_reg2ram, 8'd1, 16'h0311));
    put_word(208, jmp_word(16'd208));
    run_program("jump_skip");
  endtask

  task automatic led_and_unknown_opcode();
    new_program();
    put_word(program_base,      data_word(opc_num2reg, 8'd7, 16'h0042));
    put_word(program_base + 4,  data_word(8'h7f, 8'd7, 16'h0300));
    put_word(program_base + 8,  data_word(8'h00, 8'd7, 16'h0301));
    put_word(program_base + 12, data_word(opc_reg2ram, 8'd7, 16'h0340));
    put_word(program_base + 16, jmp_word(16'(program_base + 16)));
    run_program("led_unknown");
  endtask

  task automatic random_write_stream();
    int          addr;
    logic [31:0] rnd;
    logic [7:0]  rsel;
    new_program();
    addr = program_base;
    for (int i = 0; i < rand_count; i++) begin
      rnd  = $random(seed);
      rsel = rnd[23:16] & 8'he3;  // registers 0 to 3 with random top bits
      if (rnd[31]) begin
        put_word(addr, data_word(opc_num2reg, rsel, rnd[15:0]));
      end else begin
        put_word(addr, data_word(opc_reg2ram, rsel, {rnd[15:10], 2'b11, rnd[7:0]}));
      end
      addr += instr_bytes;
    end
    put_word(addr, jmp_word(16'(addr)));
    run_program("random_stream");
  endtask

  initial begin
    hold        = 1'b0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    model_steps = 0;
    seed        = 32'h7889;
    num2reg_then_store();
    ram2reg_copy();
    jump_skips_next();
    led_and_unknown_opcode();
    random_write_stream();
    assert_fails = cpu_top_inst.instr_executor_inst.cpu_assert_inst.fail_count;
    $display("%0d check errors, %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: cpu_top.f
common/cpu_pkg.sv
hdl/program_memory.sv
fetch/instr_fetcher.sv
execute/instr_executor.sv
hdl/cpu_top.sv
sim/clk_gen.sv
sim/cpu_assert.sv
sim/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert \
  --top-module cpu_tb \
  --Mdir "$build_dir" \
  -o cpu_sim \
  -f cpu_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$("$build_dir/cpu_sim" +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi

echo "pass message not found"
exit 1
